// File: flist.f
rtl/host_chan_pkg.sv
rtl/host_chan_ifs.sv
rtl/rd_burst_splitter.sv
rtl/rd_reorder_buf.sv
rtl/mmio_reg_pipe.sv
rtl/host_chan_avalon_top.sv
tb/tb_host_chan.sv

// File: Makefile
# Verilator simulation of the host channel adapter testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f flist.f --top-module tb_host_chan
	./obj_dir/Vtb_host_chan

clean:
	rm -rf obj_dir

// File: tb/tb_host_chan.sv
`timescale 1ns/1ps

module tb_host_chan;

    localparam int MAX_BURST = 4;
    localparam int ROB_DEPTH = 16;
    localparam int ADD_TIMING_REG_STAGES = 0;
    localparam int N_REG_STAGES = 1 + ADD_TIMING_REG_STAGES;
    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int LEN_W = $clog2(MAX_BURST + 1);
    localparam int AW = host_chan_pkg::ADDR_WIDTH;
    localparam int BW = host_chan_pkg::BURST_WIDTH;
    localparam int LW = host_chan_pkg::LINE_WIDTH;
    localparam int DW = host_chan_pkg::MMIO_DATA_WIDTH;
    localparam int TW = host_chan_pkg::MMIO_TAG_WIDTH;
    // Host memory content is the line address XOR this pattern
    localparam logic [LW-1:0] LINE_PATTERN = 64'hA5C3_0F96_5A3C_F069;
    localparam int WAIT_LIMIT = 2000;

    logic clk = 1'b0;
    logic arst_n;
    logic avs_read;
    logic [AW-1:0] avs_address;
    logic [BW-1:0] avs_burstcount;
    logic avs_waitrequest;
    logic [LW-1:0] avs_readdata;
    logic avs_readdatavalid;
    logic rd_req_valid;
    logic [AW-1:0] rd_req_addr;
    logic [LEN_W-1:0] rd_req_len;
    logic [IDX_W-1:0] rd_req_tag;
    logic rd_req_ready;
    logic cpl_valid;
    logic [IDX_W-1:0] cpl_idx;
    logic [LW-1:0] cpl_data;
    logic mmio_valid;
    host_chan_pkg::mmio_op_t mmio_op;
    logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] mmio_addr;
    logic [DW-1:0] mmio_wdata;
    logic [TW-1:0] mmio_tag;
    logic afu_mmio_valid;
    host_chan_pkg::mmio_op_t afu_mmio_op;
    logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] afu_mmio_addr;
    logic [DW-1:0] afu_mmio_wdata;
    logic [TW-1:0] afu_mmio_tag;
    logic afu_rsp_valid;
    logic [DW-1:0] afu_rsp_data;
    logic [TW-1:0] afu_rsp_tag;
    logic mmio_rsp_valid;
    logic [DW-1:0] mmio_rsp_data;
    logic [TW-1:0] mmio_rsp_tag;

    // Lines the host model still owes the adapter and its log of requests
    logic [IDX_W-1:0] pend_idx [$];
    logic [LW-1:0] pend_data [$];
    logic [AW-1:0] req_addr_log [$];
    logic [LEN_W-1:0] req_len_log [$];
    logic [IDX_W-1:0] req_tag_log [$];
    logic host_hold;

    // Every line seen on the Avalon side, and the lines the tests expect
    logic [LW-1:0] got_q [$];
    logic [LW-1:0] exp_q [$];
    int got_rd;
    // Lines requested since reset, which is also the number of slots handed out
    int lines_issued;

    // Accelerator MMIO register file and its pending read response
    logic [DW-1:0] afu_regs [256];
    logic rsp_pend;
    logic [DW-1:0] rsp_data_n;
    logic [TW-1:0] rsp_tag_n;
    int rsp_in_cyc;

    int cyc;
    logic [31:0] rng_state;

    host_chan_avalon_top
    #(
        .MAX_BURST(MAX_BURST),
        .ROB_DEPTH(ROB_DEPTH),
        .ADD_TIMING_REG_STAGES(ADD_TIMING_REG_STAGES)
    )
    i_host_chan_avalon_top
    (
        .*
    );

    always #4 clk = ~clk;

    // Cycle counter, read only away from the rising edge
    always @(posedge clk)
        cyc <= cyc + 1;

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [LW-1:0] line_data(input logic [AW-1:0] addr);
        return LW'(addr) ^ LINE_PATTERN;
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp)
        begin
            $display("Error at time %0t: %s, expected 0x%0h, got 0x%0h", $time, what, exp, act);
            abort_run();
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Presents one Avalon read command and records the lines it should return
    task automatic issue_burst(input logic [AW-1:0] addr, input int cnt);
        int t;
        avs_read = 1'b1;
        avs_address = addr;
        avs_burstcount = BW'(cnt);
        t = 0;
        @(negedge clk);
        while (avs_waitrequest)
        begin
            if (t >= WAIT_LIMIT)
            begin
                $display("Timeout: Avalon read at 0x%0h was never accepted", addr);
                abort_run();
            end
            t++;
            @(negedge clk);
        end
        next_cycle();
        avs_read = 1'b0;
        for (int k = 0; k < cnt; k++)
            exp_q.push_back(line_data(addr + AW'(k)));
        lines_issued = lines_issued + cnt;
    endtask

    // Waits for all expected lines, then compares them in issue order
    task automatic wait_lines(input string what);
        int t;
        int n;
        t = 0;
        n = exp_q.size();
        while (got_q.size() - got_rd < n)
        begin
            if (t >= WAIT_LIMIT)
            begin
                $display("Timeout: %s delivered %0d of %0d lines",
                         what, got_q.size() - got_rd, n);
                abort_run();
            end
            t++;
            next_cycle();
        end
        // A few idle cycles expose any surplus line
        repeat (8) next_cycle();
        check({what, " line count"}, 64'(n), 64'(got_q.size() - got_rd));
        for (int i = 0; i < n; i++)
            check({what, " line data"}, exp_q[i], got_q[got_rd + i]);
        got_rd = got_rd + n;
        exp_q.delete();
    endtask

    // ==============================
    // Host and accelerator models
    // ==============================

    initial
    begin : host_model
        rd_req_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl_idx = '0;
        cpl_data = '0;
        afu_rsp_valid = 1'b0;
        afu_rsp_data = '0;
        afu_rsp_tag = '0;
        rsp_pend = 1'b0;
        rsp_data_n = '0;
        rsp_tag_n = '0;
        rsp_in_cyc = 0;
        for (int i = 0; i < 256; i++)
            afu_regs[i] = {8{8'(i)}} ^ 64'h0123_4567_89AB_CDEF;
        forever
        begin
            // Outputs are sampled at the falling edge, where they are settled
            @(negedge clk);
            if (arst_n)
            begin
                if (rd_req_valid && rd_req_ready)
                begin
                    req_addr_log.push_back(rd_req_addr);
                    req_len_log.push_back(rd_req_len);
                    req_tag_log.push_back(rd_req_tag);
                    for (int k = 0; k < int'(rd_req_len); k++)
                    begin
                        pend_idx.push_back(rd_req_tag + IDX_W'(k));
                        pend_data.push_back(line_data(rd_req_addr + AW'(k)));
                    end
                end
                if (avs_readdatavalid)
                    got_q.push_back(avs_readdata);
                if (afu_mmio_valid)
                begin
                    if (afu_mmio_op == host_chan_pkg::MMIO_WR)
                        afu_regs[afu_mmio_addr[7:0]] = afu_mmio_wdata;
                    else
                    begin
                        rsp_pend = 1'b1;
                        rsp_data_n = afu_regs[afu_mmio_addr[7:0]];
                        rsp_tag_n = afu_mmio_tag;
                    end
                end
                if (afu_rsp_valid)
                    rsp_in_cyc = cyc;
            end
            next_cycle();
            // The newest outstanding line goes first, so lines return reversed
            rd_req_ready = !host_hold;
            if (!host_hold && pend_idx.size() > 0)
            begin
                cpl_valid = 1'b1;
                cpl_idx = pend_idx.pop_back();
                cpl_data = pend_data.pop_back();
            end
            else
                cpl_valid = 1'b0;
            afu_rsp_valid = rsp_pend;
            afu_rsp_data = rsp_data_n;
            afu_rsp_tag = rsp_tag_n;
            rsp_pend = 1'b0;
        end
    end

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_reset_state();
        @(negedge clk);
        check("rd_req_valid after reset", 64'd0, 64'(rd_req_valid));
        check("avs_readdatavalid after reset", 64'd0, 64'(avs_readdatavalid));
        check("mmio_rsp_valid after reset", 64'd0, 64'(mmio_rsp_valid));
        check("avs_waitrequest after reset", 64'd0, 64'(avs_waitrequest));
        next_cycle();
    endtask

    task automatic test_single_line();
        issue_burst(32'h0000_1000, 1);
        wait_lines("single-line read");
    endtask

    task automatic test_burst_split();
        int first;
        int base;
        first = req_addr_log.size();
        base = lines_issued;
        issue_burst(32'h0002_0000, 11);
        wait_lines("11-line burst");
        check("host request count", 64'd3, 64'(req_addr_log.size() - first));
        for (int i = 0; i < 3; i++)
        begin
            check("host request address", 64'(32'h0002_0000 + 4 * i),
                  64'(req_addr_log[first + i]));
            check("host request length", (i < 2) ? 64'd4 : 64'd3, 64'(req_len_log[first + i]));
            // Slots go out in issue order with one per line, so a tag is the line count so far
            check("host request tag", 64'((base + 4 * i) % ROB_DEPTH),
                  64'(req_tag_log[first + i]));
        end
    endtask

    task automatic test_out_of_order();
        int cnt;
        logic [AW-1:0] addr;
        for (int b = 0; b < 6; b++)
        begin
            cnt = 1 + int'(next_random() % 32'd24);
            addr = next_random();
            issue_burst(addr, cnt);
        end
        wait_lines("random bursts");
    endtask

    task automatic test_back_pressure();
        @(negedge clk);
        host_hold = 1'b1;
        next_cycle();
        issue_burst(32'h0030_0100, 10);
        for (int i = 0; i < 40; i++)
        begin
            @(negedge clk);
            check("avs_waitrequest while host stalls", 64'd1, 64'(avs_waitrequest));
            check("avs_readdatavalid while host stalls", 64'd0, 64'(avs_readdatavalid));
        end
        host_hold = 1'b0;
        next_cycle();
        wait_lines("back-pressure burst");
    endtask

    task automatic test_mmio();
        int t;
        int drive_cyc;
        logic [DW-1:0] wdata;
        wdata = {next_random(), next_random()};
        drive_cyc = cyc;
        mmio_valid = 1'b1;
        mmio_op = host_chan_pkg::MMIO_WR;
        mmio_addr = 16'h0040;
        mmio_wdata = wdata;
        mmio_tag = 4'h3;
        next_cycle();
        mmio_valid = 1'b0;
        t = 0;
        @(negedge clk);
        while (!afu_mmio_valid)
        begin
            if (t >= WAIT_LIMIT)
            begin
                $display("Timeout: MMIO write never reached the accelerator");
                abort_run();
            end
            t++;
            @(negedge clk);
        end
        check("MMIO write latency", 64'(N_REG_STAGES), 64'(cyc - drive_cyc));
        check("MMIO write op", 64'(host_chan_pkg::MMIO_WR), 64'(afu_mmio_op));
        check("MMIO write address", 64'h0040, 64'(afu_mmio_addr));
        check("MMIO write data", wdata, afu_mmio_wdata);
        next_cycle();
        // Read back the same register under another tag
        mmio_valid = 1'b1;
        mmio_op = host_chan_pkg::MMIO_RD;
        mmio_tag = 4'hA;
        next_cycle();
        mmio_valid = 1'b0;
        t = 0;
        @(negedge clk);
        while (!mmio_rsp_valid)
        begin
            if (t >= WAIT_LIMIT)
            begin
                $display("Timeout: MMIO read response never reached the host");
                abort_run();
            end
            t++;
            @(negedge clk);
        end
        check("MMIO response latency", 64'(N_REG_STAGES), 64'(cyc - rsp_in_cyc));
        check("MMIO response data", wdata, mmio_rsp_data);
        check("MMIO response tag", 64'hA, 64'(mmio_rsp_tag));
        next_cycle();
    endtask

    // ==============================
    // Sequence
    // ==============================

    initial
    begin
        rng_state = 32'd39910;
        host_hold = 1'b0;
        got_rd = 0;
        lines_issued = 0;
        arst_n = 1'b0;
        avs_read = 1'b0;
        avs_address = '0;
        avs_burstcount = '0;
        mmio_valid = 1'b0;
        mmio_op = host_chan_pkg::MMIO_RD;
        mmio_addr = '0;
        mmio_wdata = '0;
        mmio_tag = '0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_single_line();
        test_burst_split();
        test_out_of_order();
        test_back_pressure();
        test_mmio();

        if (got_q.size() == got_rd && exp_q.size() == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("Read data left unchecked at the end of the run");
            abort_run();
        end
    end

endmodule

// File: rtl/host_chan_avalon_top.sv
`timescale 1ns/1ps

// Host channel adapter seen by the accelerator as an Avalon-MM read
// master port, plus an MMIO path from the host through register stages
module host_chan_avalon_top
#(
    parameter int MAX_BURST = 4,
    parameter int ROB_DEPTH = 16,
    // Extra MMIO register stages on top of the one that is always there
    parameter int ADD_TIMING_REG_STAGES = 0,
    localparam int LEN_WIDTH = $clog2(MAX_BURST + 1),
    localparam int ROB_IDX_WIDTH = $clog2(ROB_DEPTH)
)
(
    input  logic                                     clk,
    input  logic                                     arst_n,

    // Accelerator Avalon read port
    input  logic                                     avs_read,
    input  logic [host_chan_pkg::ADDR_WIDTH-1:0]      avs_address,
    input  logic [host_chan_pkg::BURST_WIDTH-1:0]     avs_burstcount,
    output logic                                     avs_waitrequest,
    output logic [host_chan_pkg::LINE_WIDTH-1:0]      avs_readdata,
    output logic                                     avs_readdatavalid,

    // Host read requests and completions
    output logic                                     rd_req_valid,
    output logic [host_chan_pkg::ADDR_WIDTH-1:0]      rd_req_addr,
    output logic [LEN_WIDTH-1:0]                     rd_req_len,
    output logic [ROB_IDX_WIDTH-1:0]                 rd_req_tag,
    input  logic                                     rd_req_ready,
    input  logic                                     cpl_valid,
    input  logic [ROB_IDX_WIDTH-1:0]                 cpl_idx,
    input  logic [host_chan_pkg::LINE_WIDTH-1:0]      cpl_data,

    // MMIO from the host and toward the accelerator
    input  logic                                     mmio_valid,
    input  host_chan_pkg::mmio_op_t                  mmio_op,
    input  logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] mmio_addr,
    input  logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] mmio_wdata,
    input  logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  mmio_tag,
    output logic                                     afu_mmio_valid,
    output host_chan_pkg::mmio_op_t                  afu_mmio_op,
    output logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] afu_mmio_addr,
    output logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] afu_mmio_wdata,
    output logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  afu_mmio_tag,
    input  logic                                     afu_rsp_valid,
    input  logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] afu_rsp_data,
    input  logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  afu_rsp_tag,
    output logic                                     mmio_rsp_valid,
    output logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] mmio_rsp_data,
    output logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  mmio_rsp_tag
);

    // ==============================
    // Memory read path
    // ==============================

    rob_alloc_if #(.LEN_WIDTH(LEN_WIDTH), .IDX_WIDTH(ROB_IDX_WIDTH)) alloc_if ();

    rd_burst_splitter
    #(
        .MAX_BURST(MAX_BURST),
        .ROB_IDX_WIDTH(ROB_IDX_WIDTH)
    )
    i_rd_burst_splitter
    (
        .alloc(alloc_if.requester),
        .*
    );

    rd_reorder_buf #(.ROB_DEPTH(ROB_DEPTH)) i_rd_reorder_buf
    (
        .alloc(alloc_if.allocator),
        .*
    );

    // ==============================
    // MMIO path
    // ==============================

    // One stage is always present for timing toward the accelerator
    mmio_reg_pipe #(.N_REG_STAGES(1 + ADD_TIMING_REG_STAGES)) i_mmio_reg_pipe
    (
        .*
    );

endmodule

// File: rtl/mmio_reg_pipe.sv
`timescale 1ns/1ps

// Fixed-latency register stages for MMIO. Requests travel from the host
// toward the accelerator and read responses travel back, each through
// exactly N_REG_STAGES registers. Every stage holds its own item, so
// back-to-back requests simply follow one another down the pipe
module mmio_reg_pipe
#(
    parameter int N_REG_STAGES = 1
)
(
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     mmio_valid,
    input  host_chan_pkg::mmio_op_t                  mmio_op,
    input  logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] mmio_addr,
    input  logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] mmio_wdata,
    input  logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  mmio_tag,
    output logic                                     afu_mmio_valid,
    output host_chan_pkg::mmio_op_t                  afu_mmio_op,
    output logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] afu_mmio_addr,
    output logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] afu_mmio_wdata,
    output logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  afu_mmio_tag,
    input  logic                                     afu_rsp_valid,
    input  logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] afu_rsp_data,
    input  logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  afu_rsp_tag,
    output logic                                     mmio_rsp_valid,
    output logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] mmio_rsp_data,
    output logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  mmio_rsp_tag
);

    // Request stages, index 0 is nearest the host
    logic                                     req_valid_q [N_REG_STAGES];
    host_chan_pkg::mmio_op_t                  req_op_q    [N_REG_STAGES];
    logic [host_chan_pkg::MMIO_ADDR_WIDTH-1:0] req_addr_q  [N_REG_STAGES];
    logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] req_wdata_q [N_REG_STAGES];
    logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  req_tag_q   [N_REG_STAGES];

    // Response stages, index 0 is nearest the accelerator
    logic                                     rsp_valid_q [N_REG_STAGES];
    logic [host_chan_pkg::MMIO_DATA_WIDTH-1:0] rsp_data_q  [N_REG_STAGES];
    logic [host_chan_pkg::MMIO_TAG_WIDTH-1:0]  rsp_tag_q   [N_REG_STAGES];

    // ==============================
    // Valid bits
    // ==============================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < N_REG_STAGES; i++)
            begin
                req_valid_q[i] <= 1'b0;
                rsp_valid_q[i] <= 1'b0;
            end
        end
        else
        begin
            req_valid_q[0] <= mmio_valid;
            rsp_valid_q[0] <= afu_rsp_valid;
            for (int i = 1; i < N_REG_STAGES; i++)
            begin
                req_valid_q[i] <= req_valid_q[i-1];
                rsp_valid_q[i] <= rsp_valid_q[i-1];
            end
        end
    end

    // Payload just shifts along, qualified by the valid bit beside it
    always_ff @(posedge clk)
    begin
        req_op_q[0]    <= mmio_op;
        req_addr_q[0]  <= mmio_addr;
        req_wdata_q[0] <= mmio_wdata;
        req_tag_q[0]   <= mmio_tag;
        rsp_data_q[0]  <= afu_rsp_data;
        rsp_tag_q[0]   <= afu_rsp_tag;
        for (int i = 1; i < N_REG_STAGES; i++)
        begin
            req_op_q[i]    <= req_op_q[i-1];
            req_addr_q[i]  <= req_addr_q[i-1];
            req_wdata_q[i] <= req_wdata_q[i-1];
            req_tag_q[i]   <= req_tag_q[i-1];
            rsp_data_q[i]  <= rsp_data_q[i-1];
            rsp_tag_q[i]   <= rsp_tag_q[i-1];
        end
    end

    assign afu_mmio_valid = req_valid_q[N_REG_STAGES-1];
    assign afu_mmio_op    = req_op_q[N_REG_STAGES-1];
    assign afu_mmio_addr  = req_addr_q[N_REG_STAGES-1];
    assign afu_mmio_wdata = req_wdata_q[N_REG_STAGES-1];
    assign afu_mmio_tag   = req_tag_q[N_REG_STAGES-1];

    assign mmio_rsp_valid = rsp_valid_q[N_REG_STAGES-1];
    assign mmio_rsp_data  = rsp_data_q[N_REG_STAGES-1];
    assign mmio_rsp_tag   = rsp_tag_q[N_REG_STAGES-1];

endmodule

// File: rtl/rd_reorder_buf.sv
`timescale 1ns/1ps

// Reorder buffer for host read completions.
//
// Slots are handed out in order as contiguous ranges. The host may fill
// them in any order, but lines leave toward the accelerator strictly in
// slot order, one per cycle, as soon as the oldest slot holds data
module rd_reorder_buf
#(
    parameter int ROB_DEPTH = 16
)
(
    input  logic                                clk,
    input  logic                                arst_n,
    rob_alloc_if.allocator                      alloc,
    input  logic                                cpl_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0]        cpl_idx,
    input  logic [host_chan_pkg::LINE_WIDTH-1:0] cpl_data,
    output logic [host_chan_pkg::LINE_WIDTH-1:0] avs_readdata,
    output logic                                avs_readdatavalid
);

    localparam int IDX_WIDTH = $clog2(ROB_DEPTH);
    // One extra bit so a completely full buffer can be counted
    localparam int CNT_WIDTH = IDX_WIDTH + 1;

    logic [host_chan_pkg::LINE_WIDTH-1:0] line_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] filled;

    logic [IDX_WIDTH-1:0] alloc_ptr;
    logic [IDX_WIDTH-1:0] rel_ptr;
    logic [CNT_WIDTH-1:0] used_cnt;
    logic [CNT_WIDTH-1:0] free_cnt;

    logic grant;
    logic release_line;

    // ==============================
    // Allocation
    // ==============================

    // Slots count as used from grant until their line is released
    assign free_cnt = CNT_WIDTH'(ROB_DEPTH) - used_cnt;

    // Only ranges that fit entirely are granted, so a request never
    // overwrites a slot that still waits for release
    assign grant = alloc.alloc_req && (free_cnt >= CNT_WIDTH'(alloc.alloc_len));

    assign alloc.alloc_grant = grant;
    assign alloc.alloc_idx   = alloc_ptr;

    // ==============================
    // Release
    // ==============================

    // The oldest slot goes out as soon as its line is present. There is no
    // back-pressure from the accelerator, so a present line always leaves
    assign release_line      = filled[rel_ptr];
    assign avs_readdatavalid = release_line;
    assign avs_readdata      = line_mem[rel_ptr];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            alloc_ptr <= '0;
            rel_ptr   <= '0;
            used_cnt  <= '0;
            filled    <= '0;
        end
        else
        begin
            if (grant)
                alloc_ptr <= alloc_ptr + IDX_WIDTH'(alloc.alloc_len);

            if (release_line)
            begin
                rel_ptr         <= rel_ptr + 1'b1;
                filled[rel_ptr] <= 1'b0;
            end

            // A completion never targets the slot being released, since
            // that slot already holds its line
            if (cpl_valid)
                filled[cpl_idx] <= 1'b1;

            used_cnt <= used_cnt
                      + (grant ? CNT_WIDTH'(alloc.alloc_len) : '0)
                      - CNT_WIDTH'(release_line);
        end
    end

    // Line storage, written by the host in whatever order it answers
    always_ff @(posedge clk)
    begin
        if (cpl_valid)
            line_mem[cpl_idx] <= cpl_data;
    end

endmodule

// File: rtl/rd_burst_splitter.sv
`timescale 1ns/1ps

// Takes Avalon read bursts from the accelerator and turns each one into
// host read requests of at most MAX_BURST lines. Every request first
// reserves a range of reorder-buffer slots and carries the first slot
// of that range as its tag
module rd_burst_splitter
#(
    parameter int MAX_BURST = 4,
    parameter int ROB_IDX_WIDTH = 4,
    localparam int LEN_WIDTH = $clog2(MAX_BURST + 1)
)
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 avs_read,
    input  logic [host_chan_pkg::ADDR_WIDTH-1:0]  avs_address,
    input  logic [host_chan_pkg::BURST_WIDTH-1:0] avs_burstcount,
    output logic                                 avs_waitrequest,
    rob_alloc_if.requester                       alloc,
    output logic                                 rd_req_valid,
    output logic [host_chan_pkg::ADDR_WIDTH-1:0]  rd_req_addr,
    output logic [LEN_WIDTH-1:0]                 rd_req_len,
    output logic [ROB_IDX_WIDTH-1:0]             rd_req_tag,
    input  logic                                 rd_req_ready
);

    localparam int AW = host_chan_pkg::ADDR_WIDTH;
    localparam int BW = host_chan_pkg::BURST_WIDTH;

    // Idle until a burst is accepted, then alternate between reserving
    // slots for a chunk and handing that chunk to the host
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_ALLOC,
        ST_ISSUE
    } state_t;

    state_t               state;
    logic [BW-1:0]        rem_cnt;
    logic [AW-1:0]        next_addr;
    logic [LEN_WIDTH-1:0] chunk_len;
    logic [LEN_WIDTH-1:0] len_q;
    logic [ROB_IDX_WIDTH-1:0] tag_q;
    logic                 cmd_accept;
    logic                 req_fire;

    // New commands are refused while lines of a burst are still pending
    assign avs_waitrequest = (state != ST_IDLE);

    // A zero-length burst carries no lines and is simply dropped
    assign cmd_accept = avs_read && !avs_waitrequest && (avs_burstcount != '0);
    assign req_fire   = rd_req_valid && rd_req_ready;

    // Next chunk is the smaller of what is left and the largest host request
    assign chunk_len = (rem_cnt > BW'(MAX_BURST)) ? LEN_WIDTH'(MAX_BURST)
                                                  : rem_cnt[LEN_WIDTH-1:0];

    assign alloc.alloc_req = (state == ST_ALLOC);
    assign alloc.alloc_len = chunk_len;

    assign rd_req_valid = (state == ST_ISSUE);
    assign rd_req_addr  = next_addr;
    assign rd_req_len   = len_q;
    assign rd_req_tag   = tag_q;

    // ==============================
    // Control
    // ==============================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= ST_IDLE;
            rem_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (cmd_accept)
                    begin
                        rem_cnt <= avs_burstcount;
                        state   <= ST_ALLOC;
                    end
                end
                ST_ALLOC:
                begin
                    // rem_cnt is stable here, so alloc_len holds until granted
                    if (alloc.alloc_grant)
                        state <= ST_ISSUE;
                end
                ST_ISSUE:
                begin
                    if (req_fire)
                    begin
                        rem_cnt <= rem_cnt - BW'(len_q);
                        state   <= (rem_cnt == BW'(len_q)) ? ST_IDLE : ST_ALLOC;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Address, chunk length and tag of the request being built
    always_ff @(posedge clk)
    begin
        if (cmd_accept)
            next_addr <= avs_address;
        else if (req_fire)
            next_addr <= next_addr + AW'(len_q);

        if (alloc.alloc_req && alloc.alloc_grant)
        begin
            len_q <= chunk_len;
            tag_q <= alloc.alloc_idx;
        end
    end

endmodule

// File: rtl/host_chan_ifs.sv
`timescale 1ns/1ps

// Slot allocation handshake between the burst splitter and the
// reorder buffer.
//
// The requester drives alloc_req with the number of lines it needs in
// alloc_len. The allocator answers in the same cycle with alloc_grant
// when enough slots are free, and alloc_idx is then the first slot of
// a contiguous range that wraps at the end of the buffer
interface rob_alloc_if
#(
    parameter int LEN_WIDTH = 3,
    parameter int IDX_WIDTH = 4
);

    logic                 alloc_req;
    logic [LEN_WIDTH-1:0] alloc_len;
    logic                 alloc_grant;
    logic [IDX_WIDTH-1:0] alloc_idx;

    // Burst splitter side. Request and length stay stable until granted
    modport requester
    (
        output alloc_req,
        output alloc_len,
        input  alloc_grant,
        input  alloc_idx
    );

    // Reorder buffer side
    modport allocator
    (
        input  alloc_req,
        input  alloc_len,
        output alloc_grant,
        output alloc_idx
    );

endinterface

// File: rtl/host_chan_pkg.sv
// Widths and encodings shared by the host channel adapter and its testbench
package host_chan_pkg;

    // ==============================
    // Memory read path
    // ==============================

    // Width of one data line moved between host and accelerator
    localparam int LINE_WIDTH = 64;

    // Line address width, as seen on both the Avalon and the host side
    localparam int ADDR_WIDTH = 32;

    // Avalon burst count width, enough for bursts of up to 63 lines
    localparam int BURST_WIDTH = 6;

    // ==============================
    // MMIO path
    // ==============================

    // Register address width of an MMIO access
    localparam int MMIO_ADDR_WIDTH = 16;

    // MMIO read and write data width
    localparam int MMIO_DATA_WIDTH = 64;

    // The host attaches a tag to each MMIO read and expects it back
    // with the response, so responses can be matched to requests
    localparam int MMIO_TAG_WIDTH = 4;

    // Kind of MMIO request arriving from the host
    typedef enum logic
    {
        MMIO_RD = 1'b0,
        MMIO_WR = 1'b1
    } mmio_op_t;

endpackage
